// File: include/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// window geometry.
`define CONV_K 5
`define CONV_TAPS 25

// pixels and coefficients share one width.
`define CONV_PIX_W 6
`define CONV_SUM_W 18  // holds 25*63*63 = 99225.

// frame size is fixed at build time.
`define CONV_IMG_W 12
`define CONV_IMG_H 8

`endif

// File: hdl/conv_data_pkg.sv
`default_nettype none

`include "conv_settings.svh"

package conv_data_pkg;

  // unsigned image sample.
  typedef logic [`CONV_PIX_W-1:0] pixel_t;

  // unsigned kernel coefficient.
  typedef logic [`CONV_PIX_W-1:0] coef_t;

  typedef logic [2*`CONV_PIX_W-1:0] product_t;  // one tap, pixel times coefficient.

  typedef logic [`CONV_SUM_W-1:0] sum_t;  // full window result.

  typedef logic [$clog2(`CONV_TAPS)-1:0] tap_index_t;  // only 0 to 24 are legal.

endpackage

`default_nettype wire

// File: hdl/conv_ctrl_pkg.sv
`default_nettype none

package conv_ctrl_pkg;

  // phases of a four-phase req/ack transfer.
  typedef enum logic [1:0] {
    idle         = 2'd0,
    ack_high     = 2'd1,
    wait_release = 2'd2
  } hs_state_t;

  typedef logic [3:0] col_t;  // column within the frame.
  typedef logic [3:0] row_t;  // row within the frame.

endpackage

`default_nettype wire

// File: hdl/tap_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tap_multiplier
  import conv_data_pkg::*;
(
  input  pixel_t   a,
  input  coef_t    b,
  output product_t p
);

  always_comb begin
    product_t acc;
    acc = '0;  // sum starts empty, not at a.
    for (int k = 0; k < `CONV_PIX_W; k++) begin
      if (b[k]) begin
        acc = acc + (product_t'(a) << k);  // one partial product per set bit.
      end
    end
    p = acc;
  end

endmodule

`default_nettype wire

// File: hdl/adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module adder_tree
  import conv_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue,
  input  product_t products [`CONV_TAPS],
  output logic     done,
  output sum_t     sum
);

  sum_t lvl1 [13];
  sum_t s1   [13];
  sum_t lvl2 [7];
  sum_t lvl3 [4];
  sum_t s3   [4];
  sum_t lvl4 [2];
  logic v1;
  logic v3;

  // level 1 pairs the products, the last one passes through.
  always_comb begin
    for (int k = 0; k < 12; k++) begin
      lvl1[k] = sum_t'(products[2*k]) + sum_t'(products[2*k+1]);
    end
    lvl1[12] = sum_t'(products[24]);
  end

  // levels 2 and 3 sit between the first two register stages.
  always_comb begin
    for (int k = 0; k < 6; k++) begin
      lvl2[k] = s1[2*k] + s1[2*k+1];
    end
    lvl2[6] = s1[12];
    for (int k = 0; k < 3; k++) begin
      lvl3[k] = lvl2[2*k] + lvl2[2*k+1];
    end
    lvl3[3] = lvl2[6];
  end

  always_comb begin
    lvl4[0] = s3[0] + s3[1];
    lvl4[1] = s3[2] + s3[3];
  end

  always_ff @(posedge clk) begin
    s1  <= lvl1;
    s3  <= lvl3;
    sum <= lvl4[0] + lvl4[1];  // level 5.
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1   <= 1'b0;
      v3   <= 1'b0;
      done <= 1'b0;
    end else begin
      v1   <= issue;
      v3   <= v1;
      done <= v3;  // valid bit follows the data through each stage.
    end
  end

  a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> ##3 done);

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module line_buffer
  import conv_data_pkg::*;
#(
  parameter int DEPTH = `CONV_IMG_W
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   shift,
  input  pixel_t din,
  output pixel_t dout
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pixel_t             mem [DEPTH];
  logic [PTR_W-1:0]   ptr;

  assign dout = mem[ptr];  // oldest entry, read before it is overwritten.

  always_ff @(posedge clk) begin
    if (shift) begin
      mem[ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (shift) begin
      if (ptr == PTR_W'(DEPTH - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/window_builder.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module window_builder
  import conv_data_pkg::*, conv_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   shift,
  input  pixel_t din,
  output pixel_t win [`CONV_TAPS],
  output logic   window_full
);

  pixel_t column [`CONV_K];  // column[K-1] is the newest row.
  col_t   col;
  row_t   row;

  assign column[`CONV_K-1] = din;

  // each buffer delays one row, so the chain yields the rows above.
  for (genvar g = 0; g < `CONV_K - 1; g++) begin : g_line
    line_buffer #(
      .DEPTH(`CONV_IMG_W)
    ) u_line (
      .clk  (clk),
      .rst_n(rst_n),
      .shift(shift),
      .din  (column[`CONV_K-1-g]),
      .dout (column[`CONV_K-2-g])
    );
  end

  // rows shift left and the fresh column enters on the right.
  always_ff @(posedge clk) begin
    if (shift) begin
      for (int i = 0; i < `CONV_K; i++) begin
        for (int j = 0; j < `CONV_K - 1; j++) begin
          win[i*`CONV_K + j] <= win[i*`CONV_K + j + 1];
        end
        win[i*`CONV_K + `CONV_K - 1] <= column[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col         <= '0;
      row         <= '0;
      window_full <= 1'b0;
    end else begin
      // a pulse, raised only for the pixel that closes an inside window.
      window_full <= shift && (row >= row_t'(`CONV_K - 1)) &&
                     (col >= col_t'(`CONV_K - 1));
      if (shift) begin
        if (col == col_t'(`CONV_IMG_W - 1)) begin
          col <= '0;
          if (row == row_t'(`CONV_IMG_H - 1)) begin
            row <= '0;  // end of frame.
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/kernel_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module kernel_store
  import conv_data_pkg::*, conv_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       k_req,
  input  tap_index_t k_index,
  input  coef_t      k_data,
  output logic       k_ack,
  output coef_t      coefs [`CONV_TAPS]
);

  hs_state_t state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      k_ack <= 1'b0;
      for (int t = 0; t < `CONV_TAPS; t++) begin
        coefs[t] <= '0;  // an empty kernel until the host loads one.
      end
    end else begin
      case (state)
        idle: begin
          if (k_req) begin
            coefs[k_index] <= k_data;  // written on the edge that raises ack.
            k_ack          <= 1'b1;
            state          <= ack_high;
          end
        end
        ack_high: begin
          if (!k_req) begin
            k_ack <= 1'b0;
            state <= idle;
          end
        end
        default: begin
          k_ack <= 1'b0;
          state <= idle;
        end
      endcase
    end
  end

  a_index_legal: assert property (@(posedge clk) disable iff (!rst_n)
    k_req |-> (k_index < `CONV_TAPS));

endmodule

`default_nettype wire

// File: hdl/conv55_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv55_engine
  import conv_data_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   issue,
  input  pixel_t win   [`CONV_TAPS],
  input  coef_t  coefs [`CONV_TAPS],
  output logic   done,
  output sum_t   sum
);

  product_t prod [`CONV_TAPS];

  // tap t pairs window pixel t with coefficient t.
  for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_tap
    tap_multiplier u_mul (
      .a(win[t]),
      .b(coefs[t]),
      .p(prod[t])
    );
  end

  adder_tree u_tree (
    .clk     (clk),
    .rst_n   (rst_n),
    .issue   (issue),
    .products(prod),
    .done    (done),
    .sum     (sum)
  );

endmodule

`default_nettype wire

// File: hdl/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module conv_top
  import conv_data_pkg::*, conv_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       k_req,
  input  tap_index_t k_index,
  input  coef_t      k_data,
  output logic       k_ack,
  input  logic       pix_req,
  input  pixel_t     pix_data,
  output logic       pix_ack,
  output logic       res_req,
  output sum_t       res_data,
  input  logic       res_ack
);

  pixel_t    win   [`CONV_TAPS];
  coef_t     coefs [`CONV_TAPS];
  hs_state_t pix_state;
  hs_state_t res_state;
  logic      accept;
  logic      issue;
  logic      done;
  logic      pop;
  sum_t      eng_sum;
  logic [1:0] credit_cnt;  // sums issued and not yet handed to the sink.
  logic [1:0] slots_used;
  sum_t      res_q [2];
  logic      wr_ptr;
  logic      rd_ptr;
  logic [1:0] q_count;

  kernel_store u_kernel (
    .clk    (clk),
    .rst_n  (rst_n),
    .k_req  (k_req),
    .k_index(k_index),
    .k_data (k_data),
    .k_ack  (k_ack),
    .coefs  (coefs)
  );

  window_builder u_window (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift      (accept),
    .din        (pix_data),
    .win        (win),
    .window_full(issue)
  );

  conv55_engine u_engine (
    .clk  (clk),
    .rst_n(rst_n),
    .issue(issue),
    .win  (win),
    .coefs(coefs),
    .done (done),
    .sum  (eng_sum)
  );

  // an issue in this cycle already claims a slot.
  assign slots_used = credit_cnt + {1'b0, issue};
  assign accept     = (pix_state == idle) && pix_req && (slots_used < 2'd2);
  assign pop        = (res_state == ack_high) && res_ack;
  assign res_data   = res_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_state <= idle;
      pix_ack   <= 1'b0;
    end else begin
      case (pix_state)
        idle: begin
          if (accept) begin
            pix_ack   <= 1'b1;
            pix_state <= ack_high;
          end
        end
        ack_high: begin
          if (!pix_req) begin
            pix_ack   <= 1'b0;
            pix_state <= idle;
          end
        end
        default: begin
          pix_ack   <= 1'b0;
          pix_state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      res_q[wr_ptr] <= eng_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= '0;
      q_count    <= '0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
    end else begin
      credit_cnt <= credit_cnt + {1'b0, issue} - {1'b0, pop};
      q_count    <= q_count + {1'b0, done} - {1'b0, pop};
      wr_ptr     <= wr_ptr ^ done;
      rd_ptr     <= rd_ptr ^ pop;
    end
  end

  // requester side. ack_high here means req is up and ack is awaited.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_state <= idle;
      res_req   <= 1'b0;
    end else begin
      case (res_state)
        idle: begin
          if ((q_count != 2'd0) || done) begin
            res_req   <= 1'b1;  // a fresh sum lands in the queue on this edge.
            res_state <= ack_high;
          end
        end
        ack_high: begin
          if (res_ack) begin
            res_req   <= 1'b0;
            res_state <= wait_release;
          end
        end
        wait_release: begin
          if (!res_ack) begin
            res_state <= idle;
          end
        end
        default: begin
          res_req   <= 1'b0;
          res_state <= idle;
        end
      endcase
    end
  end

  a_pix_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    pix_req && !pix_ack |=> pix_req);

  // credits keep the engine from finishing into a full queue.
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (q_count < 2'd2));

endmodule

`default_nettype wire

// File: testbench/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_settings.svh"

module tb_conv_top
  import conv_data_pkg::*;
();

  typedef int image_t [`CONV_IMG_H][`CONV_IMG_W];
  typedef int kernel_t [`CONV_TAPS];

  localparam int WIN_PER_FRAME = (`CONV_IMG_H - `CONV_K + 1) * (`CONV_IMG_W - `CONV_K + 1);
  localparam int PIX_MAX = (1 << `CONV_PIX_W) - 1;
  localparam int MAX_SUM = `CONV_TAPS * PIX_MAX * PIX_MAX;
  localparam int HS_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 5000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       k_req;
  tap_index_t k_index;
  coef_t      k_data;
  logic       k_ack;
  logic       pix_req;
  pixel_t     pix_data;
  logic       pix_ack;
  logic       res_req;
  sum_t       res_data;
  logic       res_ack;

  image_t  img;
  kernel_t kern;
  int      exp_q [$];
  int      errors = 0;
  int      res_count = 0;
  int      tests_run = 0;
  int      tests_failed = 0;
  int      err_at_start;
  int      res_at_start;
  logic    bp_on = 1'b0;
  int      sink_state = 0;
  int      sink_delay = 0;
  int      sink_wait = 0;

  conv_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .k_req   (k_req),
    .k_index (k_index),
    .k_data  (k_data),
    .k_ack   (k_ack),
    .pix_req (pix_req),
    .pix_data(pix_data),
    .pix_ack (pix_ack),
    .res_req (res_req),
    .res_data(res_data),
    .res_ack (res_ack)
  );

  always #4 clk = ~clk;

  // window ends at (r, c), row 0 of the window is the oldest row.
  function automatic int conv_ref(input image_t image, input kernel_t k, input int r,
                                  input int c);
    int acc;
    acc = 0;
    for (int i = 0; i < `CONV_K; i++) begin
      for (int j = 0; j < `CONV_K; j++) begin
        acc += image[r - `CONV_K + 1 + i][c - `CONV_K + 1 + j] * k[i*`CONV_K + j];
      end
    end
    return acc;
  endfunction

  task automatic check_result(input sum_t got);
    int want;
    if (exp_q.size() == 0) begin
      $display("result %0d arrived at %0t ns with no result outstanding", got, $time);
      errors++;
    end else begin
      want = exp_q.pop_front();
      if (got !== sum_t'(want)) begin
        $display("error at %0t ns: res_data = %0d, expected %0d", $time, got, want);
        errors++;
      end
    end
  endtask

  // result sink, one step per clock edge.
  always @(posedge clk) begin
    if (!rst_n) begin
      res_ack    <= 1'b0;
      sink_state <= 0;
    end else begin
      case (sink_state)
        0: begin
          if (res_req) begin
            check_result(res_data);
            res_count  <= res_count + 1;
            sink_delay <= bp_on ? int'($urandom % 21) : 0;
            sink_state <= 1;
          end
        end
        1: begin
          if (sink_delay == 0) begin
            res_ack    <= 1'b1;
            sink_wait  <= 0;
            sink_state <= 2;
          end else begin
            sink_delay <= sink_delay - 1;
          end
        end
        default: begin
          if (!res_req) begin
            res_ack    <= 1'b0;
            sink_state <= 0;
          end else if (sink_wait >= HS_TIMEOUT) begin
            $display("timeout: res_req stayed high after res_ack at %0t ns", $time);
            errors++;
            res_ack    <= 1'b0;
            sink_state <= 0;
          end else begin
            sink_wait <= sink_wait + 1;
          end
        end
      endcase
    end
  end

  task automatic send_pixel(input int value);
    int n;
    pix_data <= pixel_t'(value);
    pix_req  <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!pix_ack && n < HS_TIMEOUT);
    if (!pix_ack) begin
      $display("timeout: pix_ack did not rise at %0t ns", $time);
      errors++;
    end
    pix_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (pix_ack && n < HS_TIMEOUT);
    if (pix_ack) begin
      $display("timeout: pix_ack did not fall at %0t ns", $time);
      errors++;
    end
  endtask

  task automatic write_coef(input int tap, input int value);
    int n;
    k_index <= tap_index_t'(tap);
    k_data  <= coef_t'(value);
    k_req   <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!k_ack && n < HS_TIMEOUT);
    if (!k_ack) begin
      $display("timeout: k_ack did not rise for tap %0d", tap);
      errors++;
    end
    k_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (k_ack && n < HS_TIMEOUT);
    if (k_ack) begin
      $display("timeout: k_ack did not fall for tap %0d", tap);
      errors++;
    end
  endtask

  task automatic load_kernel();
    for (int t = 0; t < `CONV_TAPS; t++) begin
      write_coef(t, kern[t]);
    end
  endtask

  task automatic send_frame();
    for (int r = 0; r < `CONV_IMG_H; r++) begin
      for (int c = 0; c < `CONV_IMG_W; c++) begin
        send_pixel(img[r][c]);  // raster order.
      end
    end
  endtask

  task automatic random_image();
    for (int r = 0; r < `CONV_IMG_H; r++) begin
      for (int c = 0; c < `CONV_IMG_W; c++) begin
        img[r][c] = int'($urandom % (PIX_MAX + 1));
      end
    end
  endtask

  task automatic random_kernel();
    for (int t = 0; t < `CONV_TAPS; t++) begin
      kern[t] = int'($urandom % (PIX_MAX + 1));
    end
  endtask

  // rule 0 uses the reference, rule 1 the centre pixel, otherwise a constant.
  task automatic expect_frame(input int rule, input int value);
    for (int r = `CONV_K - 1; r < `CONV_IMG_H; r++) begin
      for (int c = `CONV_K - 1; c < `CONV_IMG_W; c++) begin
        case (rule)
          0:       exp_q.push_back(conv_ref(img, kern, r, c));
          1:       exp_q.push_back(img[r - `CONV_K/2][c - `CONV_K/2]);
          default: exp_q.push_back(value);
        endcase
      end
    end
  endtask

  task automatic check_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("error at %0t ns: %s = %b, expected 0", $time, name, value);
      errors++;
    end
  endtask

  task automatic begin_test();
    err_at_start = errors;
    res_at_start = res_count;
  endtask

  task automatic end_test(input string name, input int frames);
    int n;
    int want;
    want = frames * WIN_PER_FRAME;
    n = 0;
    while ((res_count - res_at_start < want || sink_state != 0) && n < DRAIN_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (res_count - res_at_start < want || sink_state != 0) begin
      $display("timeout: results of %s did not all arrive", name);
      errors++;
    end
    repeat (10) @(posedge clk);  // a stray extra result would show up here.
    if (res_count - res_at_start != want) begin
      $display("error at %0t ns: result count = %0d, expected %0d", $time,
               res_count - res_at_start, want);
      errors++;
    end
    exp_q.delete();
    tests_run++;
    if (errors != err_at_start) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d results", tests_run, name,
             (errors != err_at_start) ? "fail" : "pass", res_count - res_at_start);
  endtask

  initial begin
    void'($urandom(32'h958e5c37));
    rst_n    <= 1'b0;
    k_req    <= 1'b0;
    k_index  <= '0;
    k_data   <= '0;
    pix_req  <= 1'b0;
    pix_data <= '0;
    res_ack  <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    begin_test();
    check_low("pix_ack", pix_ack);
    check_low("k_ack", k_ack);
    check_low("res_req", res_req);
    random_image();
    expect_frame(2, 0);  // kernel is still the cleared one from reset.
    send_frame();
    end_test("reset state and zero kernel", 1);

    begin_test();
    random_image();
    kern = '{default: 0};
    kern[`CONV_TAPS/2] = 1;
    load_kernel();
    expect_frame(1, 0);
    send_frame();
    end_test("identity kernel", 1);

    begin_test();
    random_image();
    random_kernel();
    load_kernel();
    expect_frame(0, 0);
    send_frame();
    end_test("random kernel and image", 1);

    begin_test();
    img  = '{default: '{default: PIX_MAX}};
    kern = '{default: PIX_MAX};
    load_kernel();
    expect_frame(2, MAX_SUM);
    send_frame();
    end_test("full scale sum", 1);

    begin_test();
    random_image();
    random_kernel();
    load_kernel();
    bp_on = 1'b1;
    expect_frame(0, 0);
    send_frame();
    end_test("delayed result ack", 1);
    bp_on = 1'b0;

    begin_test();
    random_image();
    random_kernel();
    load_kernel();
    expect_frame(0, 0);
    send_frame();
    random_image();
    random_kernel();
    load_kernel();  // first frame's sums are already past the multipliers.
    expect_frame(0, 0);
    send_frame();
    end_test("two frames back to back", 2);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hdl/conv_data_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/tap_multiplier.sv
hdl/adder_tree.sv
hdl/line_buffer.sv
hdl/window_builder.sv
hdl/kernel_store.sv
hdl/conv55_engine.sv
hdl/conv_top.sv
testbench/tb_conv_top.sv
